//--- common/pid_pkg.sv
package pid_pkg;

    // ----------------------------------------
    // Host write port
    // ----------------------------------------

    // Address and data widths of the config write port
    localparam int W_WR_ADDR = 8;
    localparam int W_WR_DATA = 32;

    // Write address map, one register per channel at each address
    // Setpoint, signed sample units
    localparam logic [W_WR_ADDR-1:0] PID_SETPOINT_ADDR  = W_WR_ADDR'(0);
    // Proportional gain
    localparam logic [W_WR_ADDR-1:0] PID_P_COEF_ADDR    = W_WR_ADDR'(1);
    // Integral gain
    localparam logic [W_WR_ADDR-1:0] PID_I_COEF_ADDR    = W_WR_ADDR'(2);
    // Derivative gain
    localparam logic [W_WR_ADDR-1:0] PID_D_COEF_ADDR    = W_WR_ADDR'(3);
    // Bit 0 set flips the error sign (bitwise inverted)
    localparam logic [W_WR_ADDR-1:0] PID_INV_ERROR_ADDR = W_WR_ADDR'(4);
    // Writing 1 flushes the channel and wipes its history
    localparam logic [W_WR_ADDR-1:0] PID_CLR_RQST_ADDR  = W_WR_ADDR'(5);

    // ----------------------------------------
    // Default sizes
    // ----------------------------------------

    // Number of sample channels
    localparam int DEF_N_CHAN = 4;
    // Signed sample width
    localparam int DEF_W_DIN = 16;
    // Signed P, I, D width
    localparam int DEF_W_PID_COEFS = 16;
    // Signed saturated output width
    localparam int DEF_W_DOUT = 32;

endpackage

//--- hdl/pid_cfg_regs.sv
`timescale 1ns/100ps

module pid_cfg_regs #(
    parameter int N_CHAN = pid_pkg::DEF_N_CHAN,
    parameter int W_DIN = pid_pkg::DEF_W_DIN,
    parameter int W_PID_COEFS = pid_pkg::DEF_W_PID_COEFS,
    localparam int W_CHAN = (N_CHAN > 1) ? $clog2(N_CHAN) : 1
) (
    input  logic clk_in,
    input  logic rst_n,
    // Host write port
    input  logic wr_en,
    input  logic [pid_pkg::W_WR_ADDR-1:0] wr_addr,
    input  logic [W_CHAN-1:0] wr_chan,
    input  logic [pid_pkg::W_WR_DATA-1:0] wr_data,
    // Channel being granted toward the filter
    input  logic [W_CHAN-1:0] chan_in,
    // Config of that channel, one cycle later
    output logic signed [W_DIN-1:0] setpoint,
    output logic signed [W_PID_COEFS-1:0] p_coef,
    output logic signed [W_PID_COEFS-1:0] i_coef,
    output logic signed [W_PID_COEFS-1:0] d_coef,
    output logic inv_error,
    // One-cycle flush pulse per channel
    output logic [N_CHAN-1:0] clr_rqst
);
    import pid_pkg::*;

    // Per-channel storage
    logic signed [W_DIN-1:0] setpoint_mem [N_CHAN];
    logic signed [W_PID_COEFS-1:0] p_coef_mem [N_CHAN];
    logic signed [W_PID_COEFS-1:0] i_coef_mem [N_CHAN];
    logic signed [W_PID_COEFS-1:0] d_coef_mem [N_CHAN];
    logic [N_CHAN-1:0] inv_error_mem;

    // ----------------------------------------
    // Host writes
    // ----------------------------------------
    always_ff @(posedge clk_in or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < N_CHAN; i++) begin
                setpoint_mem[i] <= '0;
                p_coef_mem[i] <= '0;
                i_coef_mem[i] <= '0;
                d_coef_mem[i] <= '0;
            end
            inv_error_mem <= '0;
        end else if (wr_en) begin
            // Low bits of the data word only
            case (wr_addr)
                PID_SETPOINT_ADDR:  setpoint_mem[wr_chan] <= wr_data[W_DIN-1:0];
                PID_P_COEF_ADDR:    p_coef_mem[wr_chan] <= wr_data[W_PID_COEFS-1:0];
                PID_I_COEF_ADDR:    i_coef_mem[wr_chan] <= wr_data[W_PID_COEFS-1:0];
                PID_D_COEF_ADDR:    d_coef_mem[wr_chan] <= wr_data[W_PID_COEFS-1:0];
                PID_INV_ERROR_ADDR: inv_error_mem[wr_chan] <= wr_data[0];
                default: ;
            endcase
        end
    end

    // Clear request, self-clearing after one cycle
    always_ff @(posedge clk_in or negedge rst_n) begin
        if (!rst_n) begin
            clr_rqst <= '0;
        end else begin
            clr_rqst <= '0;
            if (wr_en && (wr_addr == PID_CLR_RQST_ADDR) && wr_data[0]) begin
                clr_rqst[wr_chan] <= 1'b1;
            end
        end
    end

    // ----------------------------------------
    // Fetch for filter stage 1
    // ----------------------------------------
    always_ff @(posedge clk_in) begin
        setpoint <= setpoint_mem[chan_in];
        p_coef <= p_coef_mem[chan_in];
        i_coef <= i_coef_mem[chan_in];
        d_coef <= d_coef_mem[chan_in];
        inv_error <= inv_error_mem[chan_in];
    end

endmodule

//--- hdl/chan_arbiter.sv
`timescale 1ns/100ps

module chan_arbiter #(
    parameter int N_CHAN = pid_pkg::DEF_N_CHAN,
    parameter int W_DIN = pid_pkg::DEF_W_DIN,
    localparam int W_CHAN = (N_CHAN > 1) ? $clog2(N_CHAN) : 1
) (
    input  logic clk_in,
    input  logic rst_n,
    // Sample sources
    input  logic [N_CHAN-1:0] sample_valid,
    input  logic [N_CHAN-1:0][W_DIN-1:0] sample_data,
    output logic [N_CHAN-1:0] sample_ready,
    // Stream toward the filter
    output logic dv_in,
    output logic [W_CHAN-1:0] chan_in,
    output logic signed [W_DIN-1:0] data_in
);
    // One pending sample per channel
    logic [N_CHAN-1:0] pend_valid;
    logic [W_DIN-1:0] pend_data [N_CHAN];
    logic [N_CHAN-1:0] capture;

    // Round-robin state
    logic [W_CHAN-1:0] last_grant;
    logic grant_found;
    logic [W_CHAN-1:0] grant_idx;
    logic [N_CHAN-1:0] grant_mask;

    // Ready means the holder is empty
    assign sample_ready = ~pend_valid;
    // Strobes while full are dropped
    assign capture = sample_valid & sample_ready;

    // Search starts just after the last winner
    always_comb begin
        int idx;
        grant_found = 1'b0;
        grant_idx = last_grant;
        for (int k = 1; k <= N_CHAN; k++) begin
            idx = int'(last_grant) + k;
            if (idx >= N_CHAN) begin
                idx = idx - N_CHAN;
            end
            if (!grant_found && pend_valid[idx]) begin
                grant_found = 1'b1;
                grant_idx = W_CHAN'(idx);
            end
        end
    end

    assign grant_mask = grant_found ? (N_CHAN'(1) << grant_idx) : '0;

    // ----------------------------------------
    // Holders
    // ----------------------------------------
    always_ff @(posedge clk_in or negedge rst_n) begin
        if (!rst_n) begin
            pend_valid <= '0;
        end else begin
            // Grant and capture never hit the same holder
            pend_valid <= (pend_valid & ~grant_mask) | capture;
        end
    end

    always_ff @(posedge clk_in) begin
        for (int i = 0; i < N_CHAN; i++) begin
            if (capture[i]) begin
                pend_data[i] <= sample_data[i];
            end
        end
    end

    // ----------------------------------------
    // Registered grant stream
    // ----------------------------------------
    always_ff @(posedge clk_in or negedge rst_n) begin
        if (!rst_n) begin
            dv_in <= 1'b0;
            // Channel 0 wins first
            last_grant <= W_CHAN'(N_CHAN - 1);
        end else begin
            dv_in <= grant_found;
            if (grant_found) begin
                last_grant <= grant_idx;
            end
        end
    end

    always_ff @(posedge clk_in) begin
        chan_in <= grant_idx;
        data_in <= pend_data[grant_idx];
    end

endmodule

//--- pid_filter/pid_filter.sv
`timescale 1ns/100ps

module pid_filter #(
    parameter int N_CHAN = pid_pkg::DEF_N_CHAN,
    parameter int W_DIN = pid_pkg::DEF_W_DIN,
    parameter int W_PID_COEFS = pid_pkg::DEF_W_PID_COEFS,
    parameter int W_DOUT = pid_pkg::DEF_W_DOUT,
    localparam int W_CHAN = (N_CHAN > 1) ? $clog2(N_CHAN) : 1
) (
    input  logic clk_in,
    input  logic rst_n,
    // Sample stream from the arbiter
    input  logic dv_in,
    input  logic [W_CHAN-1:0] chan_in,
    input  logic signed [W_DIN-1:0] data_in,
    // Config, aligned with stage 1
    input  logic signed [W_DIN-1:0] setpoint,
    input  logic signed [W_PID_COEFS-1:0] p_coef,
    input  logic signed [W_PID_COEFS-1:0] i_coef,
    input  logic signed [W_PID_COEFS-1:0] d_coef,
    input  logic inv_error,
    input  logic [N_CHAN-1:0] clr_rqst,
    // Result
    output logic dv_out,
    output logic [W_CHAN-1:0] chan_out,
    output logic signed [W_DOUT-1:0] data_out
);
    // Internal widths, grown to avoid overflow before saturation
    localparam int W_ERROR = W_DIN + 1;
    localparam int W_K_COEFS = W_PID_COEFS + 2;
    localparam int W_CE_PROD = W_K_COEFS + W_ERROR;
    localparam int W_DELTA = W_CE_PROD + 2;
    localparam int W_DOUT_UC = ((W_DOUT > W_DELTA) ? W_DOUT : W_DELTA) + 1;

    // Signed output limits
    localparam logic signed [W_DOUT-1:0] MAX_DOUT = {1'b0, {(W_DOUT - 1){1'b1}}};
    localparam logic signed [W_DOUT-1:0] MIN_DOUT = {1'b1, {(W_DOUT - 1){1'b0}}};

    // Per-channel history
    logic signed [W_ERROR-1:0] error_prev1_mem [N_CHAN];
    logic signed [W_ERROR-1:0] error_prev2_mem [N_CHAN];
    logic signed [W_DOUT-1:0] dout_prev_mem [N_CHAN];

    // Valid flags and channel tags down the pipe
    logic dv_p1, dv_p2, dv_p3, dv_p4, dv_p5, dv_p6;
    logic [W_CHAN-1:0] chan_p1, chan_p2, chan_p3, chan_p4, chan_p5, chan_p6;

    // Stage payloads
    logic signed [W_DIN-1:0] din_p1;
    logic signed [W_ERROR-1:0] error_raw;
    logic signed [W_ERROR-1:0] error_p2, error_prev1_p2, error_prev2_p2;
    logic signed [W_K_COEFS-1:0] k1_p2, k2_p2, k3_p2;
    logic signed [W_CE_PROD-1:0] ce_prod1_p3, ce_prod2_p3, ce_prod3_p3;
    logic signed [W_DELTA-1:0] delta_p4;
    logic signed [W_DOUT-1:0] dout_prev_fwd, dout_prev_p4;
    logic signed [W_DOUT_UC-1:0] dout_uc;
    logic signed [W_DOUT-1:0] dout_p5, dout_p6;

    // ----------------------------------------
    // Valid flags with per-channel flush
    // ----------------------------------------
    always_ff @(posedge clk_in or negedge rst_n) begin
        if (!rst_n) begin
            dv_p1 <= 1'b0;
            dv_p2 <= 1'b0;
            dv_p3 <= 1'b0;
            dv_p4 <= 1'b0;
            dv_p5 <= 1'b0;
            dv_p6 <= 1'b0;
        end else begin
            // Item dies if its channel is being cleared
            dv_p1 <= dv_in && !clr_rqst[chan_in];
            dv_p2 <= dv_p1 && !clr_rqst[chan_p1];
            dv_p3 <= dv_p2 && !clr_rqst[chan_p2];
            dv_p4 <= dv_p3 && !clr_rqst[chan_p3];
            dv_p5 <= dv_p4 && !clr_rqst[chan_p4];
            dv_p6 <= dv_p5 && !clr_rqst[chan_p5];
        end
    end

    // Stage 1, input register; config arrives from the fetch
    always_ff @(posedge clk_in) begin
        chan_p1 <= chan_in;
        din_p1 <= data_in;
    end

    // ----------------------------------------
    // Stage 2, error and k coefficients
    // ----------------------------------------
    assign error_raw = setpoint - din_p1;

    always_ff @(posedge clk_in) begin
        chan_p2 <= chan_p1;
        error_p2 <= inv_error ? ~error_raw : error_raw;
        // Velocity form coefficients
        k1_p2 <= p_coef + i_coef + d_coef;
        k2_p2 <= -p_coef - (d_coef <<< 1);
        k3_p2 <= d_coef;
        // e[n-1], e[n-2]
        error_prev1_p2 <= error_prev1_mem[chan_p1];
        error_prev2_p2 <= error_prev2_mem[chan_p1];
    end

    // Stage 3, coefficient times error
    always_ff @(posedge clk_in) begin
        chan_p3 <= chan_p2;
        ce_prod1_p3 <= k1_p2 * error_p2;
        ce_prod2_p3 <= k2_p2 * error_prev1_p2;
        ce_prod3_p3 <= k3_p2 * error_prev2_p2;
    end

    // ----------------------------------------
    // Stage 4, delta and previous output
    // ----------------------------------------
    // Same channel two grants apart is still in stage 5 here
    assign dout_prev_fwd = (dv_p5 && (chan_p5 == chan_p3)) ? dout_p5
                                                           : dout_prev_mem[chan_p3];

    always_ff @(posedge clk_in) begin
        chan_p4 <= chan_p3;
        delta_p4 <= ce_prod1_p3 + ce_prod2_p3 + ce_prod3_p3;
        dout_prev_p4 <= dout_prev_fwd;
    end

    // Stage 5, accumulate and clamp
    assign dout_uc = dout_prev_p4 + delta_p4;

    always_ff @(posedge clk_in) begin
        chan_p5 <= chan_p4;
        if (dout_uc > MAX_DOUT) begin
            dout_p5 <= MAX_DOUT;
        end else if (dout_uc < MIN_DOUT) begin
            dout_p5 <= MIN_DOUT;
        end else begin
            dout_p5 <= dout_uc[W_DOUT-1:0];
        end
    end

    // Stage 6, output register
    always_ff @(posedge clk_in) begin
        chan_p6 <= chan_p5;
        dout_p6 <= dout_p5;
    end

    // ----------------------------------------
    // History writeback and clear
    // ----------------------------------------
    always_ff @(posedge clk_in or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < N_CHAN; i++) begin
                error_prev1_mem[i] <= '0;
                error_prev2_mem[i] <= '0;
                dout_prev_mem[i] <= '0;
            end
        end else begin
            // Error history shifts as stage 2 moves on
            if (dv_p2) begin
                error_prev1_mem[chan_p2] <= error_p2;
                error_prev2_mem[chan_p2] <= error_prev1_p2;
            end
            // Clamped output becomes next y[n-1]
            if (dv_p5) begin
                dout_prev_mem[chan_p5] <= dout_p5;
            end
            // Clear wins over writeback
            for (int i = 0; i < N_CHAN; i++) begin
                if (clr_rqst[i]) begin
                    error_prev1_mem[i] <= '0;
                    error_prev2_mem[i] <= '0;
                    dout_prev_mem[i] <= '0;
                end
            end
        end
    end

    assign dv_out = dv_p6;
    assign chan_out = chan_p6;
    assign data_out = dout_p6;

endmodule

//--- hdl/pid_top.sv
`timescale 1ns/100ps

module pid_top #(
    parameter int N_CHAN = pid_pkg::DEF_N_CHAN,
    parameter int W_DIN = pid_pkg::DEF_W_DIN,
    parameter int W_PID_COEFS = pid_pkg::DEF_W_PID_COEFS,
    parameter int W_DOUT = pid_pkg::DEF_W_DOUT,
    localparam int W_CHAN = (N_CHAN > 1) ? $clog2(N_CHAN) : 1
) (
    input  logic clk_in,
    input  logic rst_n,
    // Sample sources
    input  logic [N_CHAN-1:0] sample_valid,
    input  logic [N_CHAN-1:0][W_DIN-1:0] sample_data,
    output logic [N_CHAN-1:0] sample_ready,
    // Host config writes
    input  logic wr_en,
    input  logic [pid_pkg::W_WR_ADDR-1:0] wr_addr,
    input  logic [W_CHAN-1:0] wr_chan,
    input  logic [pid_pkg::W_WR_DATA-1:0] wr_data,
    // Controller output
    output logic dv_out,
    output logic [W_CHAN-1:0] chan_out,
    output logic signed [W_DOUT-1:0] data_out
);
    // Arbiter stream, also the config fetch channel
    logic dv_in;
    logic [W_CHAN-1:0] chan_in;
    logic signed [W_DIN-1:0] data_in;

    // Fetched config and clear pulses
    logic signed [W_DIN-1:0] setpoint;
    logic signed [W_PID_COEFS-1:0] p_coef;
    logic signed [W_PID_COEFS-1:0] i_coef;
    logic signed [W_PID_COEFS-1:0] d_coef;
    logic inv_error;
    logic [N_CHAN-1:0] clr_rqst;

    chan_arbiter #(
        .N_CHAN(N_CHAN),
        .W_DIN(W_DIN)
    ) u_arbiter (
        .clk_in(clk_in),
        .rst_n(rst_n),
        .sample_valid(sample_valid),
        .sample_data(sample_data),
        .sample_ready(sample_ready),
        .dv_in(dv_in),
        .chan_in(chan_in),
        .data_in(data_in)
    );

    pid_cfg_regs #(
        .N_CHAN(N_CHAN),
        .W_DIN(W_DIN),
        .W_PID_COEFS(W_PID_COEFS)
    ) u_cfg_regs (
        .clk_in(clk_in),
        .rst_n(rst_n),
        .wr_en(wr_en),
        .wr_addr(wr_addr),
        .wr_chan(wr_chan),
        .wr_data(wr_data),
        .chan_in(chan_in),
        .setpoint(setpoint),
        .p_coef(p_coef),
        .i_coef(i_coef),
        .d_coef(d_coef),
        .inv_error(inv_error),
        .clr_rqst(clr_rqst)
    );

    pid_filter #(
        .N_CHAN(N_CHAN),
        .W_DIN(W_DIN),
        .W_PID_COEFS(W_PID_COEFS),
        .W_DOUT(W_DOUT)
    ) u_filter (
        .clk_in(clk_in),
        .rst_n(rst_n),
        .dv_in(dv_in),
        .chan_in(chan_in),
        .data_in(data_in),
        .setpoint(setpoint),
        .p_coef(p_coef),
        .i_coef(i_coef),
        .d_coef(d_coef),
        .inv_error(inv_error),
        .clr_rqst(clr_rqst),
        .dv_out(dv_out),
        .chan_out(chan_out),
        .data_out(data_out)
    );

endmodule

//--- verification/pid_model.svh
`ifndef PID_MODEL_SVH
`define PID_MODEL_SVH

// ----------------------------------------
// PID reference model, lives inside pid_tb
// ----------------------------------------

// Shadow of the per-channel config
longint model_sp [DEF_N_CHAN];
longint model_p [DEF_N_CHAN];
longint model_i [DEF_N_CHAN];
longint model_d [DEF_N_CHAN];
bit model_inv [DEF_N_CHAN];

// History: e[n-1], e[n-2], y[n-1]
longint model_e1 [DEF_N_CHAN];
longint model_e2 [DEF_N_CHAN];
longint model_y [DEF_N_CHAN];

// Expected outputs per channel, oldest first
longint exp_q [DEF_N_CHAN][$];

// Signed output range
localparam longint OUT_MAX = (64'sd1 <<< (DEF_W_DOUT - 1)) - 1;
localparam longint OUT_MIN = -(64'sd1 <<< (DEF_W_DOUT - 1));

// Sign-extend the low width bits
function automatic longint sext(input longint value, input int width);
    return (value <<< (64 - width)) >>> (64 - width);
endfunction

function automatic void model_clear_history(input int chan);
    model_e1[chan] = 0;
    model_e2[chan] = 0;
    model_y[chan] = 0;
endfunction

// Everything zero, as after reset
function automatic void model_reset();
    for (int c = 0; c < DEF_N_CHAN; c++) begin
        model_sp[c] = 0;
        model_p[c] = 0;
        model_i[c] = 0;
        model_d[c] = 0;
        model_inv[c] = 1'b0;
        model_clear_history(c);
        exp_q[c].delete();
    end
endfunction

// Mirror of one host write
function automatic void model_write(input logic [W_WR_ADDR-1:0] addr, input int chan,
                                    input logic [W_WR_DATA-1:0] data);
    case (addr)
        PID_SETPOINT_ADDR:  model_sp[chan] = sext(longint'(data), DEF_W_DIN);
        PID_P_COEF_ADDR:    model_p[chan] = sext(longint'(data), DEF_W_PID_COEFS);
        PID_I_COEF_ADDR:    model_i[chan] = sext(longint'(data), DEF_W_PID_COEFS);
        PID_D_COEF_ADDR:    model_d[chan] = sext(longint'(data), DEF_W_PID_COEFS);
        PID_INV_ERROR_ADDR: model_inv[chan] = data[0];
        PID_CLR_RQST_ADDR:  if (data[0]) model_clear_history(chan);
        default: ;
    endcase
endfunction

// Velocity form: y = y[n-1] + k1*e + k2*e[n-1] + k3*e[n-2], then clamp
function automatic void model_sample(input int chan, input logic [DEF_W_DIN-1:0] x);
    longint err;
    longint y;
    err = model_sp[chan] - sext(longint'(x), DEF_W_DIN);
    if (model_inv[chan]) begin
        err = ~err;
    end
    y = model_y[chan]
        + (model_p[chan] + model_i[chan] + model_d[chan]) * err
        + (-model_p[chan] - 2 * model_d[chan]) * model_e1[chan]
        + model_d[chan] * model_e2[chan];
    if (y > OUT_MAX) begin
        y = OUT_MAX;
    end else if (y < OUT_MIN) begin
        y = OUT_MIN;
    end
    model_e2[chan] = model_e1[chan];
    model_e1[chan] = err;
    model_y[chan] = y;
    exp_q[chan].push_back(y);
endfunction

// Samples still waiting for their output
function automatic int outstanding();
    int total;
    total = 0;
    for (int c = 0; c < DEF_N_CHAN; c++) begin
        total += exp_q[c].size();
    end
    return total;
endfunction

`endif

//--- verification/pid_tb.sv
`timescale 1ns/100ps

module pid_tb;
    import pid_pkg::*;

    localparam int W_CHAN = (DEF_N_CHAN > 1) ? $clog2(DEF_N_CHAN) : 1;
    // Rough length of all tests, timeout leaves margin
    localparam int TEST_CYCLES = 1200;
    localparam int TIMEOUT_CYCLES = TEST_CYCLES * 5 / 2;

    logic clk_in;
    logic rst_n;
    logic [DEF_N_CHAN-1:0] sample_valid;
    logic [DEF_N_CHAN-1:0][DEF_W_DIN-1:0] sample_data;
    logic [DEF_N_CHAN-1:0] sample_ready;
    logic wr_en;
    logic [W_WR_ADDR-1:0] wr_addr;
    logic [W_CHAN-1:0] wr_chan;
    logic [W_WR_DATA-1:0] wr_data;
    logic dv_out;
    logic [W_CHAN-1:0] chan_out;
    logic signed [DEF_W_DOUT-1:0] data_out;

    string cur_test = "none";
    int cycle_count = 0;
    longint last_out [DEF_N_CHAN];
    // Arbiter grants, six cycles deep
    logic [5:0] dv_hist = '0;
    logic [5:0][W_CHAN-1:0] chan_hist = '0;

    `include "pid_model.svh"

    pid_top #(
        .N_CHAN(DEF_N_CHAN),
        .W_DIN(DEF_W_DIN),
        .W_PID_COEFS(DEF_W_PID_COEFS),
        .W_DOUT(DEF_W_DOUT)
    ) uut (
        .clk_in(clk_in),
        .rst_n(rst_n),
        .sample_valid(sample_valid),
        .sample_data(sample_data),
        .sample_ready(sample_ready),
        .wr_en(wr_en),
        .wr_addr(wr_addr),
        .wr_chan(wr_chan),
        .wr_data(wr_data),
        .dv_out(dv_out),
        .chan_out(chan_out),
        .data_out(data_out)
    );

    // 40 ns period
    always #20 clk_in = ~clk_in;

    // ----------------------------------------
    // Failure reports
    // ----------------------------------------
    task automatic fail_value(input string what, input longint expected, input longint actual);
        $display("ERROR in %s: %s expected %0d actual %0d", cur_test, what, expected, actual);
        $display("Errors found");
        $fatal(1, "Value mismatch");
    endtask

    task automatic fail_plain(input string msg);
        $display("%s", msg);
        $display("Errors found");
        $fatal(1, "Run aborted");
    endtask

    // ----------------------------------------
    // Output monitor, outputs are stable at the falling edge
    // ----------------------------------------
    always @(negedge clk_in) begin
        longint expected;
        int c;
        cycle_count++;
        assert (cycle_count < TIMEOUT_CYCLES)
            else fail_plain($sformatf("Timeout after %0d cycles", cycle_count));
        if (rst_n) begin
            // Fixed filter latency from the arbiter grant
            assert (dv_out == dv_hist[5]) else fail_value("dv_out latency", dv_hist[5], dv_out);
            if (dv_out) begin
                c = int'(chan_out);
                assert (outstanding() > 0)
                    else fail_plain("Output seen while no sample was outstanding");
                assert (chan_out == chan_hist[5]) else fail_value("chan_out", chan_hist[5], c);
                assert (exp_q[c].size() > 0)
                    else fail_plain($sformatf("Unexpected output on channel %0d", c));
                expected = exp_q[c].pop_front();
                assert (longint'(data_out) == expected)
                    else fail_value($sformatf("data_out ch%0d", c), expected, data_out);
                last_out[c] = data_out;
            end
            dv_hist = {dv_hist[4:0], uut.dv_in};
            chan_hist = {chan_hist[4:0], uut.chan_in};
        end
    end

    // ----------------------------------------
    // Stimulus helpers, all called at a falling edge
    // ----------------------------------------
    task automatic write_cfg(input logic [W_WR_ADDR-1:0] addr, input int chan, input int value);
        wr_en = 1'b1;
        wr_addr = addr;
        wr_chan = W_CHAN'(chan);
        wr_data = W_WR_DATA'(value);
        model_write(addr, chan, wr_data);
        @(negedge clk_in);
        wr_en = 1'b0;
    endtask

    task automatic program_chan(input int chan, input int sp, input int p, input int i,
                                input int d, input int inv);
        write_cfg(PID_SETPOINT_ADDR, chan, sp);
        write_cfg(PID_P_COEF_ADDR, chan, p);
        write_cfg(PID_I_COEF_ADDR, chan, i);
        write_cfg(PID_D_COEF_ADDR, chan, d);
        write_cfg(PID_INV_ERROR_ADDR, chan, inv);
    endtask

    task automatic clear_chan(input int chan);
        write_cfg(PID_CLR_RQST_ADDR, chan, 1);
        @(negedge clk_in);
    endtask

    task automatic wait_ready(input logic [DEF_N_CHAN-1:0] mask);
        while ((sample_ready & mask) != mask) @(negedge clk_in);
    endtask

    // Every sent sample has come out
    task automatic wait_idle();
        while (outstanding() != 0) @(negedge clk_in);
    endtask

    task automatic send_samples(input logic [DEF_N_CHAN-1:0] mask,
                                input logic [DEF_N_CHAN-1:0][DEF_W_DIN-1:0] values);
        for (int c = 0; c < DEF_N_CHAN; c++) begin
            if (mask[c]) begin
                assert (sample_ready[c])
                    else fail_plain($sformatf("Stimulus strobed busy channel %0d", c));
                model_sample(c, values[c]);
            end
        end
        sample_valid = mask;
        sample_data = values;
        @(negedge clk_in);
        sample_valid = '0;
    endtask

    // One sample, then wait for its output
    task automatic send_one(input int chan, input logic [DEF_W_DIN-1:0] value);
        logic [DEF_N_CHAN-1:0][DEF_W_DIN-1:0] values;
        values = '0;
        values[chan] = value;
        wait_ready(DEF_N_CHAN'(1) << chan);
        send_samples(DEF_N_CHAN'(1) << chan, values);
        wait_idle();
    endtask

    // All channels strobed on the same edge
    task automatic run_bursts(input int count);
        logic [DEF_N_CHAN-1:0][DEF_W_DIN-1:0] values;
        for (int n = 0; n < count; n++) begin
            wait_ready('1);
            for (int c = 0; c < DEF_N_CHAN; c++) begin
                values[c] = DEF_W_DIN'($urandom());
            end
            send_samples('1, values);
            repeat ($urandom_range(0, 2)) @(negedge clk_in);
        end
    endtask

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------
    initial begin
        void'($urandom(17));
        clk_in = 1'b0;
        rst_n = 1'b0;
        sample_valid = '0;
        sample_data = '0;
        wr_en = 1'b0;
        wr_addr = '0;
        wr_chan = '0;
        wr_data = '0;
        model_reset();
        repeat (4) @(posedge clk_in);
        @(negedge clk_in);
        rst_n = 1'b1;

        // Idle after reset
        cur_test = "reset";
        repeat (5) begin
            @(negedge clk_in);
            assert (sample_ready == '1) else fail_value("sample_ready", 15, sample_ready);
            assert (!dv_out) else fail_value("dv_out", 0, dv_out);
        end

        // Single channel recursion
        cur_test = "single_channel";
        program_chan(0, 500, 12, 5, -3, 0);
        for (int n = 0; n < 20; n++) begin
            send_one(0, DEF_W_DIN'($urandom()));
            repeat ($urandom_range(0, 3)) @(negedge clk_in);
        end

        // Inverted error drives the integrator into both rails
        cur_test = "saturation";
        program_chan(1, -30000, 100, 32767, 50, 1);
        repeat (6) send_one(1, DEF_W_DIN'(30000));
        assert (last_out[1] == OUT_MAX) else fail_value("upper clamp", OUT_MAX, last_out[1]);
        write_cfg(PID_SETPOINT_ADDR, 1, 30000);
        repeat (8) send_one(1, DEF_W_DIN'(-30000));
        assert (last_out[1] == OUT_MIN) else fail_value("lower clamp", OUT_MIN, last_out[1]);

        // Contention on all channels, each with its own gains
        cur_test = "arbitration";
        for (int c = 0; c < DEF_N_CHAN; c++) begin
            program_chan(c, 100 * c - 150, 3 + c, 1 + c, 2 * c - 3, (c == 3) ? 1 : 0);
        end
        run_bursts(10);
        wait_idle();

        // Channel 2 restarts from zero history
        cur_test = "clear";
        clear_chan(2);
        run_bursts(8);
        wait_idle();
        clear_chan(2);
        run_bursts(6);
        wait_idle();

        // No late or extra outputs
        repeat (10) @(negedge clk_in);
        for (int c = 0; c < DEF_N_CHAN; c++) begin
            assert (exp_q[c].size() == 0)
                else fail_plain($sformatf("Missing output on channel %0d", c));
        end
        $display("No errors");
        $finish;
    end

endmodule

//--- vlog.f
+incdir+verification
common/pid_pkg.sv
hdl/pid_cfg_regs.sv
hdl/chan_arbiter.sv
pid_filter/pid_filter.sv
hdl/pid_top.sv
verification/pid_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the PID testbench with Verilator, result decided from sim.log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --top-module pid_tb -Mdir obj_dir \
    -f vlog.f > sim.log 2>&1 \
    && ./obj_dir/Vpid_tb >> sim.log 2>&1

grep -qx "No errors" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed, see sim.log"; exit 1; }
